/* ifetch.f */
verilog/ifetch_pkg.sv
verilog/icache_lookup_if.sv
verilog/sync_ram.sv
verilog/icache_arrays.sv
verilog/fetch_queue.sv
verilog/access_counters.sv
verilog/fetch_ctrl.sv
verilog/ifetch_top.sv
test/ifetch_mem_model.sv
test/ifetch_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ifetch_tb \
   -f ifetch.f -o ifetch_sim || exit 1

./obj_dir/ifetch_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* test/ifetch_mem_model.sv */
`timescale 1ns/1ns

module ifetch_mem_model
(
   input  logic              clk,
   input  logic              reset,
   input  logic              mem_req_valid,
   input  ifetch_pkg::addr_t mem_req_addr,
   output logic              mem_rsp_valid,
   output ifetch_pkg::line_t mem_rsp_data
);
   import ifetch_pkg::*;

   logic  pending;
   addr_t req_addr;
   int    wait_cnt;

   // direct jumps in the program image, zero where there is none
   function automatic int jump_offset(addr_t a);
      case (a)
         32'h0000_1018: return 40;
         32'h0000_104c: return -68;
         default:       return 0;
      endcase
   endfunction

   function automatic insn_t encode_jal(int off);
      logic [20:0] o;
      o = off[20:0];
      return {o[20], o[10:1], o[11], o[19:12], 5'd1, JAL_OPCODE};
   endfunction

   // addi-style word that carries its own address
   function automatic insn_t image_word(addr_t a);
      if (jump_offset(a) != 0)
      begin
         return encode_jal(jump_offset(a));
      end
      return {a[26:2], 7'h13};
   endfunction

   function automatic line_t read_line(addr_t a);
      line_t l;
      for (int w = 0; w < WORDS_PER_LINE; w++)
      begin
         l[32*w +: 32] = image_word({a[31:4], 4'b0000} + 32'(4 * w));
      end
      return l;
   endfunction

   initial
   begin
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      pending = 1'b0;
      req_addr = '0;
      wait_cnt = 0;
   end

   // answer 1 to 6 cycles after the request
   always
   begin
      @(posedge clk);
      #5;
      mem_rsp_valid = 1'b0;
      if (reset)
      begin
         pending = 1'b0;
      end
      else if (pending)
      begin
         if (wait_cnt == 0)
         begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data = read_line(req_addr);
            pending = 1'b0;
         end
         else
         begin
            wait_cnt = wait_cnt - 1;
         end
      end
      if (mem_req_valid && !reset)
      begin
         pending = 1'b1;
         req_addr = mem_req_addr;
         wait_cnt = int'($urandom % 6);
      end
   end

endmodule

/* test/ifetch_tb.sv */
`timescale 1ns/1ns

module ifetch_tb;
   import ifetch_pkg::*;

   localparam int COUNT_W = 32;
   localparam int NUM_ROWS = 5;
   localparam int SWEEP_CYCLES = 16;

   logic               clk;
   logic               reset;
   logic               flush_req;
   logic               flush_complete;
   logic               restart_valid;
   addr_t              restart_pc;
   logic               restart_ack;
   logic               insn_valid;
   logic               insn_ack;
   addr_t              insn_pc;
   insn_t              insn_data;
   logic               insn_pred;
   addr_t              insn_pred_target;
   logic               mem_req_valid;
   addr_t              mem_req_addr;
   logic               mem_rsp_valid;
   line_t              mem_rsp_data;
   logic [COUNT_W-1:0] cache_accesses;
   logic [COUNT_W-1:0] cache_hits;

   // name, restart pc, count, stall, flush first, memory requests (0 none, 1 some)
   string row_name [NUM_ROWS] = '{"cold_start", "warm_hits", "backpressure",
                                  "flush_cold", "mid_restart"};
   addr_t row_pc [NUM_ROWS] = '{32'h1000, 32'h1000, 32'h1000, 32'h1040, 32'h1044};
   int    row_count [NUM_ROWS] = '{12, 12, 20, 8, 6};
   bit    row_stall [NUM_ROWS] = '{0, 0, 1, 0, 0};
   bit    row_flush [NUM_ROWS] = '{0, 0, 0, 1, 0};
   int    row_reqs [NUM_ROWS] = '{1, 0, 0, 1, 0};

   int cycles;
   int limit;

   ifetch_top #(.COUNT_W(COUNT_W)) dut_i (.*);

   ifetch_mem_model mem_i (
      .clk           (clk),
      .reset         (reset),
      .mem_req_valid (mem_req_valid),
      .mem_req_addr  (mem_req_addr),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data)
   );

   always #20 clk = !clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (limit != 0 && cycles > limit)
      begin
         $display("run did not finish within %0d cycles", limit);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_entry(string name, fetch_entry_t exp, fetch_entry_t act);
      if (exp !== act)
      begin
         $write("[FAIL] %s expected pc=%h data=%h pred=%b tgt=%h",
                name, exp.pc, exp.data, exp.pred, exp.pred_target);
         $display(" actual pc=%h data=%h pred=%b tgt=%h",
                  act.pc, act.data, act.pred, act.pred_target);
         stop_run();
      end
   endtask

   task automatic check_addr(string name, addr_t exp, addr_t act);
      if (exp !== act)
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_count(string name, logic [COUNT_W-1:0] exp, logic [COUNT_W-1:0] act);
      if (exp !== act)
      begin
         $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
         stop_run();
      end
   endtask

   // inputs change 5 ns after the edge, outputs are stable there
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic watch_memory(string name, inout int reqs);
      if (mem_req_valid)
      begin
         reqs = reqs + 1;
         // a request names a whole line
         check_addr({name, " mem_req_addr line offset"}, '0,
                    addr_t'(mem_req_addr[LG_LINE_BYTES-1:0]));
      end
      if (cache_hits > cache_accesses)
      begin
         $display("%s: cache_hits %0d exceeds cache_accesses %0d",
                  name, cache_hits, cache_accesses);
         stop_run();
      end
   endtask

   task automatic run_flush(string name);
      int reqs;
      reqs = 0;
      flush_req = 1'b1;
      next_cycle();
      flush_req = 1'b0;
      while (!flush_complete)
      begin
         watch_memory(name, reqs);
         next_cycle();
      end
      check_count({name, " insn_valid after flush"}, 0, 32'(insn_valid));
      next_cycle();
      check_count({name, " flush_complete width"}, 0, 32'(flush_complete));
   endtask

   task automatic run_row(int r);
      string        name;
      addr_t        pc;
      fetch_entry_t exp;
      int           taken;
      int           reqs;
      int           off;
      logic [COUNT_W-1:0] hits_before;

      name = row_name[r];
      pc = row_pc[r];
      taken = 0;
      reqs = 0;
      if (row_flush[r])
      begin
         run_flush(name);
      end
      hits_before = cache_hits;
      restart_valid = 1'b1;
      restart_pc = row_pc[r];
      next_cycle();
      restart_valid = 1'b0;
      while (!restart_ack)
      begin
         next_cycle();
      end
      check_count({name, " queue cleared on restart"}, 0, 32'(insn_valid));
      if (row_stall[r])
      begin
         repeat (40)
         begin
            next_cycle();
            watch_memory(name, reqs);
         end
         check_count({name, " insn_valid while stalled"}, 1, 32'(insn_valid));
      end
      while (taken < row_count[r])
      begin
         insn_ack = 1'b0;
         if (insn_valid && ($urandom % 4 != 0))
         begin
            off = mem_i.jump_offset(pc);
            exp.pc = pc;
            exp.data = mem_i.image_word(pc);
            exp.pred = (off != 0);
            exp.pred_target = pc + ((off != 0) ? off : 4);
            check_entry($sformatf("%s entry %0d", name, taken), exp,
                        {insn_pc, insn_data, insn_pred, insn_pred_target});
            pc = exp.pred_target;
            taken = taken + 1;
            insn_ack = 1'b1;
         end
         next_cycle();
         watch_memory(name, reqs);
      end
      insn_ack = 1'b0;
      if (row_reqs[r] == 1 && reqs == 0)
      begin
         $display("%s: no memory request was issued for a cold cache", name);
         stop_run();
      end
      if (row_reqs[r] == 0)
      begin
         check_count({name, " mem requests"}, 0, reqs);
         if (cache_hits <= hits_before)
         begin
            $display("%s: cache_hits did not rise on a warm pass", name);
            stop_run();
         end
      end
   endtask

   initial
   begin
      int total;
      int reqs;
      clk = 1'b0;
      reset = 1'b1;
      flush_req = 1'b0;
      restart_valid = 1'b0;
      restart_pc = '0;
      insn_ack = 1'b0;
      cycles = 0;
      reqs = 0;
      void'($urandom(32'h665f_9f96));

      total = 0;
      limit = 0;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         total = total + row_count[r];
         limit = limit + (row_flush[r] ? SWEEP_CYCLES : 0);
      end
      limit = limit + total * 20 + SWEEP_CYCLES;

      repeat (4) @(posedge clk);
      #5;
      check_count("reset insn_valid", 0, 32'(insn_valid));
      check_count("reset restart_ack", 0, 32'(restart_ack));
      check_count("reset mem_req_valid", 0, 32'(mem_req_valid));
      check_count("reset flush_complete", 0, 32'(flush_complete));
      reset = 1'b0;

      // initial sweep after reset
      while (!flush_complete)
      begin
         watch_memory("reset sweep", reqs);
         next_cycle();
      end
      next_cycle();
      check_count("reset flush_complete once", 0, 32'(flush_complete));
      check_count("reset sweep mem requests", 0, reqs);

      for (int r = 0; r < NUM_ROWS; r++)
      begin
         run_row(r);
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

/* verilog/access_counters.sv */
`timescale 1ns/1ns

module access_counters #(parameter int COUNT_W = 32)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               access,
   input  logic               hit,
   output logic [COUNT_W-1:0] cache_accesses,
   output logic [COUNT_W-1:0] cache_hits
);

   // plain wrapping counters
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         if (access)
         begin
            cache_accesses <= cache_accesses + 1'b1;
         end
         if (hit)
         begin
            cache_hits <= cache_hits + 1'b1;
         end
      end
   end

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ns

module fetch_ctrl #(parameter int LG_NUM_SETS = 4)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     flush_req,
   input  logic                     restart_valid,
   input  ifetch_pkg::addr_t        restart_pc,
   input  logic                     mem_rsp_valid,
   input  logic                     fq_full,
   output logic                     flush_complete,
   output logic                     restart_ack,
   output logic                     fq_clear,
   output logic                     push,
   output ifetch_pkg::fetch_entry_t push_entry,
   output logic                     mem_req_valid,
   output ifetch_pkg::addr_t        mem_req_addr,
   icache_lookup_if.ctrl            lookup
);
   import ifetch_pkg::*;

   localparam int IDX_LO = LG_LINE_BYTES;
   localparam int TAG_LO = LG_LINE_BYTES + LG_NUM_SETS;

   typedef enum logic [2:0] {
      FLUSH_SWEEP,
      IDLE,
      ACTIVE,
      RELOAD_WAIT,
      RELOAD_TURN,
      WAIT_NOT_FULL
   } state_t;

   state_t                 r_state, n_state;
   addr_t                  r_pc, n_pc;
   addr_t                  r_cache_pc;
   addr_t                  r_miss_pc, n_miss_pc;
   addr_t                  r_mem_req_addr, n_mem_req_addr;
   logic [LG_NUM_SETS-1:0] r_sweep_idx, n_sweep_idx;
   logic                   r_flush_req, n_flush_req;
   logic                   r_restart_req, n_restart_req;
   logic                   r_restart_ack, n_restart_ack;
   logic                   r_flush_complete, n_flush_complete;
   logic                   r_mem_req_valid, n_mem_req_valid;
   logic                   r_bubble, n_bubble;

   addr_t                  t_lookup_pc;
   addr_t                  t_jump_target;
   insn_t                  t_insn;
   logic                   t_lookup;
   logic                   t_pred;
   logic                   t_redirect_ok;

   assign t_insn = lookup.insn;

   // J-type immediate added to the jump's own pc
   assign t_jump_target = r_cache_pc + {{12{t_insn[31]}}, t_insn[19:12], t_insn[20],
                                        t_insn[30:21], 1'b0};

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_miss_pc = r_miss_pc;
      n_mem_req_addr = r_mem_req_addr;
      n_sweep_idx = r_sweep_idx;
      n_flush_req = r_flush_req | flush_req;
      n_restart_req = r_restart_req | restart_valid;
      n_restart_ack = 1'b0;
      n_flush_complete = 1'b0;
      n_mem_req_valid = 1'b0;
      n_bubble = 1'b0;
      t_lookup = 1'b0;
      t_lookup_pc = r_pc;
      t_redirect_ok = 1'b0;
      t_pred = 1'b0;
      push = 1'b0;
      fq_clear = 1'b0;

      case (r_state)
         FLUSH_SWEEP:
         begin
            n_sweep_idx = r_sweep_idx + 1'b1;
            if (&r_sweep_idx)
            begin
               n_flush_complete = 1'b1;
               n_state = IDLE;
            end
         end
         IDLE:
         begin
            t_redirect_ok = 1'b1;
         end
         ACTIVE:
         begin
            // look up r_pc while the previous result resolves
            t_lookup = 1'b1;
            n_pc = r_pc + 32'd4;
            t_redirect_ok = !r_bubble;
            if (!r_bubble && lookup.miss)
            begin
               t_lookup = 1'b0;
               n_pc = r_pc;
               n_miss_pc = r_cache_pc;
               n_mem_req_valid = 1'b1;
               n_mem_req_addr = {r_cache_pc[31:IDX_LO], {IDX_LO{1'b0}}};
               n_state = RELOAD_WAIT;
            end
            else if (!r_bubble && lookup.hit && fq_full)
            begin
               // replay this pc once there is room
               t_lookup = 1'b0;
               n_pc = r_pc;
               n_miss_pc = r_cache_pc;
               n_state = WAIT_NOT_FULL;
            end
            else if (!r_bubble && lookup.hit)
            begin
               push = 1'b1;
               t_pred = lookup.is_jump;
               if (lookup.is_jump)
               begin
                  // fall-through lookup now in flight gets dropped
                  n_pc = t_jump_target;
                  n_bubble = 1'b1;
               end
            end
         end
         RELOAD_WAIT:
         begin
            if (mem_rsp_valid)
            begin
               n_state = RELOAD_TURN;
            end
         end
         RELOAD_TURN:
         begin
            t_redirect_ok = 1'b1;
            t_lookup_pc = r_miss_pc;
            if (!fq_full)
            begin
               t_lookup = 1'b1;
               n_state = ACTIVE;
            end
         end
         WAIT_NOT_FULL:
         begin
            t_redirect_ok = 1'b1;
            t_lookup_pc = r_miss_pc;
            if (!fq_full)
            begin
               t_lookup = 1'b1;
               n_state = ACTIVE;
            end
         end
         default:
         begin
            n_state = FLUSH_SWEEP;
         end
      endcase

      // pending flush first, then restart
      if (t_redirect_ok && n_flush_req)
      begin
         n_flush_req = 1'b0;
         fq_clear = 1'b1;
         n_sweep_idx = '0;
         n_state = FLUSH_SWEEP;
         t_lookup = 1'b0;
         push = 1'b0;
         n_mem_req_valid = 1'b0;
         n_bubble = 1'b0;
      end
      else if (t_redirect_ok && n_restart_req)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         fq_clear = 1'b1;
         n_pc = restart_pc;
         n_state = ACTIVE;
         t_lookup = 1'b0;
         push = 1'b0;
         n_mem_req_valid = 1'b0;
         n_bubble = 1'b0;
      end
   end

   always_comb
   begin
      push_entry.pc = r_cache_pc;
      push_entry.data = t_insn;
      push_entry.pred = t_pred;
      push_entry.pred_target = t_pred ? t_jump_target : r_cache_pc + 32'd4;
   end

   assign lookup.lookup_req = t_lookup;
   assign lookup.lookup_idx = t_lookup_pc[TAG_LO-1:IDX_LO];
   assign lookup.lookup_tag = t_lookup_pc[31:TAG_LO];
   assign lookup.lookup_word = t_lookup_pc[IDX_LO-1:2];

   // line is written in the cycle it arrives
   assign lookup.fill_en = (r_state == RELOAD_WAIT) && mem_rsp_valid;
   assign lookup.fill_idx = r_mem_req_addr[TAG_LO-1:IDX_LO];
   assign lookup.fill_tag = r_mem_req_addr[31:TAG_LO];

   assign lookup.inval_en = (r_state == FLUSH_SWEEP);
   assign lookup.inval_idx = r_sweep_idx;

   assign flush_complete = r_flush_complete;
   assign restart_ack = r_restart_ack;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = r_mem_req_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_SWEEP;
         r_sweep_idx <= '0;
         r_flush_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_mem_req_addr <= '0;
         r_bubble <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_sweep_idx <= n_sweep_idx;
         r_flush_req <= n_flush_req;
         r_restart_req <= n_restart_req;
         r_restart_ack <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_mem_req_valid <= n_mem_req_valid;
         r_mem_req_addr <= n_mem_req_addr;
         r_bubble <= n_bubble;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_miss_pc <= n_miss_pc;
      if (t_lookup)
      begin
         r_cache_pc <= t_lookup_pc;
      end
   end

endmodule

/* verilog/fetch_queue.sv */
`timescale 1ns/1ns

module fetch_queue #(parameter int LG_FQ_ENTRIES = 3)
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clear,
   input  logic                     push,
   input  ifetch_pkg::fetch_entry_t push_entry,
   input  logic                     pop,
   output ifetch_pkg::fetch_entry_t head,
   output logic                     empty,
   output logic                     full
);
   import ifetch_pkg::*;

   localparam int DEPTH = 1 << LG_FQ_ENTRIES;

   fetch_entry_t mem [0:DEPTH-1];

   // one extra bit tells full from empty
   logic [LG_FQ_ENTRIES:0] r_head_ptr;
   logic [LG_FQ_ENTRIES:0] r_tail_ptr;
   logic                   t_push;
   logic                   t_pop;

   assign empty = (r_head_ptr == r_tail_ptr);
   assign full = (r_head_ptr[LG_FQ_ENTRIES] != r_tail_ptr[LG_FQ_ENTRIES]) &&
                 (r_head_ptr[LG_FQ_ENTRIES-1:0] == r_tail_ptr[LG_FQ_ENTRIES-1:0]);

   assign t_push = push && !full;
   assign t_pop = pop && !empty;

   assign head = mem[r_head_ptr[LG_FQ_ENTRIES-1:0]];

   always_ff @(posedge clk)
   begin
      if (t_push)
      begin
         mem[r_tail_ptr[LG_FQ_ENTRIES-1:0]] <= push_entry;
      end
   end

   // clear wins over a push or pop in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         if (t_push)
         begin
            r_tail_ptr <= r_tail_ptr + 1'b1;
         end
         if (t_pop)
         begin
            r_head_ptr <= r_head_ptr + 1'b1;
         end
      end
   end

endmodule

/* verilog/icache_arrays.sv */
`timescale 1ns/1ns

module icache_arrays #(parameter int LG_NUM_SETS = 4)
(
   input  logic              clk,
   input  ifetch_pkg::line_t mem_rsp_data,
   output logic              access,
   output logic              hit,
   icache_lookup_if.cache    lookup
);
   import ifetch_pkg::*;

   localparam int TAG_W = $bits(addr_t) - LG_NUM_SETS - LG_LINE_BYTES;
   localparam int INSN_W = $bits(insn_t);

   typedef logic [TAG_W-1:0] tag_t;

   logic                     r_req;
   tag_t                     r_tag;
   logic [LG_LINE_BYTES-3:0] r_word;

   logic                     valid_out;
   tag_t                     tag_out;
   line_t                    line_out;
   pd_t                      pd_out;
   pd_t                      fill_pd;

   logic                     valid_wr_en;
   logic                     valid_wr_data;
   logic [LG_NUM_SETS-1:0]   valid_wr_addr;
   logic                     t_match;

   // predecode the incoming line, one jump bit per word
   always_comb
   begin
      for (int w = 0; w < WORDS_PER_LINE; w++)
      begin
         fill_pd[w] = (mem_rsp_data[INSN_W*w +: 7] == JAL_OPCODE);
      end
   end

   // fill sets the valid bit, the sweep clears it
   assign valid_wr_en = lookup.fill_en | lookup.inval_en;
   assign valid_wr_addr = lookup.inval_en ? lookup.inval_idx : lookup.fill_idx;
   assign valid_wr_data = !lookup.inval_en;

   sync_ram #(.payload_t(logic), .LG_DEPTH(LG_NUM_SETS)) valid_ram (
      .clk     (clk),
      .rd_addr (lookup.lookup_idx),
      .wr_en   (valid_wr_en),
      .wr_addr (valid_wr_addr),
      .wr_data (valid_wr_data),
      .rd_data (valid_out)
   );

   sync_ram #(.payload_t(tag_t), .LG_DEPTH(LG_NUM_SETS)) tag_ram (
      .clk     (clk),
      .rd_addr (lookup.lookup_idx),
      .wr_en   (lookup.fill_en),
      .wr_addr (lookup.fill_idx),
      .wr_data (lookup.fill_tag),
      .rd_data (tag_out)
   );

   sync_ram #(.payload_t(line_t), .LG_DEPTH(LG_NUM_SETS)) line_ram (
      .clk     (clk),
      .rd_addr (lookup.lookup_idx),
      .wr_en   (lookup.fill_en),
      .wr_addr (lookup.fill_idx),
      .wr_data (mem_rsp_data),
      .rd_data (line_out)
   );

   sync_ram #(.payload_t(pd_t), .LG_DEPTH(LG_NUM_SETS)) pd_ram (
      .clk     (clk),
      .rd_addr (lookup.lookup_idx),
      .wr_en   (lookup.fill_en),
      .wr_addr (lookup.fill_idx),
      .wr_data (fill_pd),
      .rd_data (pd_out)
   );

   // request, tag and word travel alongside the array read
   always_ff @(posedge clk)
   begin
      r_req <= lookup.lookup_req;
      r_tag <= lookup.lookup_tag;
      r_word <= lookup.lookup_word;
   end

   assign t_match = valid_out && (tag_out == r_tag);

   assign lookup.hit = r_req & t_match;
   assign lookup.miss = r_req & !t_match;
   assign lookup.insn = line_out[INSN_W*r_word +: INSN_W];
   assign lookup.is_jump = pd_out[r_word];

   // statistics taps
   assign access = r_req;
   assign hit = r_req & t_match;

endmodule

/* verilog/icache_lookup_if.sv */
`timescale 1ns/1ns

interface icache_lookup_if #(parameter int LG_NUM_SETS = 4);
   import ifetch_pkg::*;

   localparam int TAG_W = $bits(addr_t) - LG_NUM_SETS - LG_LINE_BYTES;

   // lookup request, answered one cycle later
   logic                     lookup_req;
   logic [LG_NUM_SETS-1:0]   lookup_idx;
   logic [TAG_W-1:0]         lookup_tag;
   logic [LG_LINE_BYTES-3:0] lookup_word;

   // line fill from memory
   logic                     fill_en;
   logic [LG_NUM_SETS-1:0]   fill_idx;
   logic [TAG_W-1:0]         fill_tag;

   // invalidation sweep
   logic                     inval_en;
   logic [LG_NUM_SETS-1:0]   inval_idx;

   // result of the previous cycle's lookup
   logic                     hit;
   logic                     miss;
   insn_t                    insn;
   logic                     is_jump;

   modport ctrl (
      output lookup_req, lookup_idx, lookup_tag, lookup_word,
      output fill_en, fill_idx, fill_tag,
      output inval_en, inval_idx,
      input  hit, miss, insn, is_jump
   );

   modport cache (
      input  lookup_req, lookup_idx, lookup_tag, lookup_word,
      input  fill_en, fill_idx, fill_tag,
      input  inval_en, inval_idx,
      output hit, miss, insn, is_jump
   );

endinterface

/* verilog/ifetch_pkg.sv */
package ifetch_pkg;

   // fetch address and instruction word
   typedef logic [31:0] addr_t;
   typedef logic [31:0] insn_t;

   // cache line geometry
   localparam int WORDS_PER_LINE = 4;
   localparam int LG_LINE_BYTES = 4;

   // word 0 in the low bits
   typedef logic [WORDS_PER_LINE*$bits(insn_t)-1:0] line_t;

   // one direct-jump marker per word of a line
   typedef logic [WORDS_PER_LINE-1:0] pd_t;

   // entry held in the fetch queue
   typedef struct packed {
      addr_t pc;
      insn_t data;
      logic  pred;
      addr_t pred_target;
   } fetch_entry_t;

   // major opcode shared by jal and j
   localparam logic [6:0] JAL_OPCODE = 7'h6f;

endpackage

/* verilog/ifetch_top.sv */
`timescale 1ns/1ns

module ifetch_top #(
   parameter int LG_NUM_SETS = 4,
   parameter int LG_FQ_ENTRIES = 3,
   parameter int COUNT_W = 32
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               flush_req,
   output logic               flush_complete,
   input  logic               restart_valid,
   input  ifetch_pkg::addr_t  restart_pc,
   output logic               restart_ack,
   output logic               insn_valid,
   input  logic               insn_ack,
   output ifetch_pkg::addr_t  insn_pc,
   output ifetch_pkg::insn_t  insn_data,
   output logic               insn_pred,
   output ifetch_pkg::addr_t  insn_pred_target,
   output logic               mem_req_valid,
   output ifetch_pkg::addr_t  mem_req_addr,
   input  logic               mem_rsp_valid,
   input  ifetch_pkg::line_t  mem_rsp_data,
   output logic [COUNT_W-1:0] cache_accesses,
   output logic [COUNT_W-1:0] cache_hits
);
   import ifetch_pkg::*;

   fetch_entry_t push_entry;
   fetch_entry_t head_entry;
   logic         fq_clear;
   logic         push;
   logic         fq_full;
   logic         fq_empty;
   logic         access;
   logic         hit;

   icache_lookup_if #(.LG_NUM_SETS(LG_NUM_SETS)) lookup_bus ();

   fetch_ctrl #(.LG_NUM_SETS(LG_NUM_SETS)) u_ctrl (
      .clk            (clk),
      .reset          (reset),
      .flush_req      (flush_req),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .mem_rsp_valid  (mem_rsp_valid),
      .fq_full        (fq_full),
      .flush_complete (flush_complete),
      .restart_ack    (restart_ack),
      .fq_clear       (fq_clear),
      .push           (push),
      .push_entry     (push_entry),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .lookup         (lookup_bus.ctrl)
   );

   icache_arrays #(.LG_NUM_SETS(LG_NUM_SETS)) u_arrays (
      .clk          (clk),
      .mem_rsp_data (mem_rsp_data),
      .access       (access),
      .hit          (hit),
      .lookup       (lookup_bus.cache)
   );

   // entry leaves on insn_valid and insn_ack together
   fetch_queue #(.LG_FQ_ENTRIES(LG_FQ_ENTRIES)) u_queue (
      .clk        (clk),
      .reset      (reset),
      .clear      (fq_clear),
      .push       (push),
      .push_entry (push_entry),
      .pop        (insn_ack),
      .head       (head_entry),
      .empty      (fq_empty),
      .full       (fq_full)
   );

   access_counters #(.COUNT_W(COUNT_W)) u_counters (
      .clk            (clk),
      .reset          (reset),
      .access         (access),
      .hit            (hit),
      .cache_accesses (cache_accesses),
      .cache_hits     (cache_hits)
   );

   assign insn_valid = !fq_empty;
   assign insn_pc = head_entry.pc;
   assign insn_data = head_entry.data;
   assign insn_pred = head_entry.pred;
   assign insn_pred_target = head_entry.pred_target;

endmodule

/* verilog/sync_ram.sv */
`timescale 1ns/1ns

module sync_ram #(
   parameter type payload_t = logic,
   parameter int  LG_DEPTH = 4
)
(
   input  logic                clk,
   input  logic [LG_DEPTH-1:0] rd_addr,
   input  logic                wr_en,
   input  logic [LG_DEPTH-1:0] wr_addr,
   input  payload_t            wr_data,
   output payload_t            rd_data
);

   localparam int DEPTH = 1 << LG_DEPTH;

   payload_t mem [0:DEPTH-1];

   // read returns the old contents on a same-address write
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
   end

endmodule
